//--- dprx_lnk_pkg.sv
// Link layer definitions for the receiver: symbol codes, lane layout, stream widths, parser states
package dprx_lnk_pkg;

    // Lane layout
    localparam int LANES  = 2;                      // Lanes per link
    localparam int SYM_W  = 9;                      // K flag plus byte
    localparam int LNK_W  = LANES * SYM_W;          // Whole link word, lane 0 low
    localparam int PAIR_W = LANES * 8;              // Data bytes per cycle

    // Control symbol codes, only meaningful with the K flag set
    localparam logic [7:0] K_BS = 8'hBC;            // Blanking start
    localparam logic [7:0] K_BE = 8'hFB;            // Blanking end
    localparam logic [7:0] K_SS = 8'h5C;            // Secondary packet start
    localparam logic [7:0] K_SE = 8'hFD;            // Secondary packet end

    // Output streams
    localparam int VID_W = 48;                      // Two pixels of 3 x 8 bit components
    localparam int SDP_W = 32;

    // Video FIFO
    localparam int FIFO_DEPTH = 4;
    localparam int FIFO_AW    = $clog2(FIFO_DEPTH); // Pointers carry one extra wrap bit

    // Parser states
    localparam logic [1:0] ST_BLANK  = 2'd0;        // Between BS and BE
    localparam logic [1:0] ST_VBID   = 2'd1;        // Waiting for the VB-ID byte
    localparam logic [1:0] ST_ACTIVE = 2'd2;        // Active line data
    localparam logic [1:0] ST_SDP    = 2'd3;        // Inside SS ... SE

endpackage

//--- dprx_msg_pkg.sv
// Host message definitions: message IDs and the word shared by control and status views
package dprx_msg_pkg;

    localparam int MSG_W = 16;                      // Message word width

    // IDs in the top nibble
    localparam logic [3:0] MSG_ID_CTL = 4'd1;       // Control request
    localparam logic [3:0] MSG_ID_STA = 4'd2;       // Status request

    // Control view, host to receiver
    typedef struct packed {
        logic [3:0] id;
        logic [8:0] rsvd;
        logic       clr_ovf;                        // Clear sticky video overflow
        logic       sdp_en;                         // Secondary data enable
        logic       vid_en;                         // Video enable
    } msg_ctl_t;

    // Status view, receiver to host
    typedef struct packed {
        logic [3:0] id;
        logic [7:0] vbid;                           // Latest VB-ID
        logic       ovf;                            // Video FIFO overflow seen
        logic       lock;                           // Link symbol lock
        logic [1:0] rsvd;
    } msg_sta_t;

    // One 16 bit word, decoded by its id
    typedef union packed {
        msg_ctl_t ctl;
        msg_sta_t sta;
    } msg_word_t;

endpackage

//--- dprx_lnk_parser.sv
// Link parser: classifies each symbol pair, tracks sync, lock and VB-ID, steers data bytes
`timescale 1ns/10ps

module dprx_lnk_parser
(
    input  logic                                lnk_clk,
    input  logic                                rst,
    input  logic [dprx_lnk_pkg::LNK_W-1:0]      lnk_dat,        // K flag in bit 8 of each lane
    output logic                                lnk_sync,       // Pulse the cycle after BS
    output logic [7:0]                          lnk_vbid,
    output logic                                lock,
    output logic                                vblank,         // VB-ID bit 0
    output logic                                line_end,       // Pulse on BS
    output logic                                vid_byte_vld,
    output logic [dprx_lnk_pkg::PAIR_W-1:0]     vid_bytes,
    output logic                                sdp_byte_vld,
    output logic [dprx_lnk_pkg::PAIR_W-1:0]     sdp_bytes,
    output logic                                sdp_start,
    output logic                                sdp_end
);

    logic                               k0;             // Lane 0 K flag
    logic [7:0]                         d0;             // Lane 0 byte
    logic                               is_bs;
    logic                               is_be;
    logic                               is_ss;
    logic                               is_se;
    logic                               k_legal;        // One of the four known codes
    logic                               dat_sym;        // No K flag on any lane
    logic [dprx_lnk_pkg::PAIR_W-1:0]    pair;
    logic [dprx_lnk_pkg::PAIR_W-1:0]    pair_q;         // Registered byte pair
    logic [1:0]                         state;
    logic [1:0]                         state_nxt;
    logic                               sdp_from_act;   // Packet opened inside active video

    // Control codes are decoded on lane 0, the other lanes repeat them
    assign k0      = lnk_dat[8];
    assign d0      = lnk_dat[7:0];
    assign is_bs   = k0 && (d0 == dprx_lnk_pkg::K_BS);
    assign is_be   = k0 && (d0 == dprx_lnk_pkg::K_BE);
    assign is_ss   = k0 && (d0 == dprx_lnk_pkg::K_SS);
    assign is_se   = k0 && (d0 == dprx_lnk_pkg::K_SE);
    assign k_legal = is_bs || is_be || is_ss || is_se;

    // Gather lane bytes, lane 0 into the low byte
    always_comb
    begin
        dat_sym = 1'b1;
        for (int i = 0; i < dprx_lnk_pkg::LANES; i++)
        begin
            pair[i*8 +: 8] = lnk_dat[i*dprx_lnk_pkg::SYM_W +: 8];
            dat_sym        = dat_sym && !lnk_dat[i*dprx_lnk_pkg::SYM_W + 8];
        end
    end

    // Next state, control symbols win over the current state
    always_comb
    begin
        state_nxt = state;
        if (is_bs)
            state_nxt = dprx_lnk_pkg::ST_VBID;
        else if (is_be)
            state_nxt = dprx_lnk_pkg::ST_ACTIVE;
        else if (is_ss)
            state_nxt = dprx_lnk_pkg::ST_SDP;
        else
        begin
            case (state)
                dprx_lnk_pkg::ST_VBID:
                    if (dat_sym)
                        state_nxt = dprx_lnk_pkg::ST_BLANK;     // Single VB-ID byte
                dprx_lnk_pkg::ST_SDP:
                    if (is_se)
                        state_nxt = sdp_from_act ? dprx_lnk_pkg::ST_ACTIVE
                                                 : dprx_lnk_pkg::ST_BLANK;
                default:
                    state_nxt = state;
            endcase
        end
    end

    always_ff @(posedge lnk_clk)
    begin
        if (rst)
        begin
            state        <= dprx_lnk_pkg::ST_BLANK;
            sdp_from_act <= 1'b0;
            lnk_sync     <= 1'b0;
            line_end     <= 1'b0;
            lnk_vbid     <= 8'h00;
            lock         <= 1'b0;
            vid_byte_vld <= 1'b0;
            sdp_byte_vld <= 1'b0;
            sdp_start    <= 1'b0;
            sdp_end      <= 1'b0;
        end
        else
        begin
            state     <= state_nxt;
            lnk_sync  <= is_bs;
            line_end  <= is_bs;
            sdp_start <= is_ss;
            sdp_end   <= is_se;

            // Data steering follows the state the byte arrived in
            vid_byte_vld <= dat_sym && (state == dprx_lnk_pkg::ST_ACTIVE);
            sdp_byte_vld <= dat_sym && (state == dprx_lnk_pkg::ST_SDP);

            if (is_ss)
                sdp_from_act <= (state == dprx_lnk_pkg::ST_ACTIVE);

            if ((state == dprx_lnk_pkg::ST_VBID) && dat_sym)
                lnk_vbid <= d0;                                 // Byte after BS

            // Unknown K code drops lock, next BS regains it
            if (k0 && !k_legal)
                lock <= 1'b0;
            else if (is_bs)
                lock <= 1'b1;
        end
    end

    always_ff @(posedge lnk_clk)
    begin
        pair_q <= pair;
    end

    assign vid_bytes = pair_q;
    assign sdp_bytes = pair_q;          // Same pair, qualified by its own valid
    assign vblank    = lnk_vbid[0];

endmodule

//--- dprx_vid_pack.sv
// Video packer: gathers byte pairs into two-pixel words, stages them for framing, FIFO output
`timescale 1ns/10ps

module dprx_vid_pack
(
    input  logic                                lnk_clk,
    input  logic                                rst,
    input  logic                                vid_en,
    input  logic                                vblank,
    input  logic                                line_end,
    input  logic                                vid_byte_vld,
    input  logic [dprx_lnk_pkg::PAIR_W-1:0]     vid_bytes,
    input  logic                                clr_ovf,
    input  logic                                vid_rdy,
    output logic                                vid_sof,
    output logic                                vid_eol,
    output logic [dprx_lnk_pkg::VID_W-1:0]      vid_dat,
    output logic                                vid_vld,
    output logic                                ovf             // Sticky until clr_ovf
);

    logic [1:0]                         phase;          // Byte pair index in word
    logic [2*dprx_lnk_pkg::PAIR_W-1:0]  acc;            // First two pairs
    logic                               take;
    logic                               word_done;
    logic                               sof_pend;       // Next word opens a frame
    logic                               stg_vld;
    logic                               stg_sof;
    logic [dprx_lnk_pkg::VID_W-1:0]     stg_dat;
    logic                               push;
    logic                               push_eol;
    logic [dprx_lnk_pkg::VID_W+1:0]     mem [dprx_lnk_pkg::FIFO_DEPTH];     // {sof, eol, dat}
    logic [dprx_lnk_pkg::VID_W+1:0]     head;
    logic [dprx_lnk_pkg::FIFO_AW:0]     wr_ptr;
    logic [dprx_lnk_pkg::FIFO_AW:0]     rd_ptr;
    logic                               full;
    logic                               empty;

    assign take      = vid_en && vid_byte_vld;
    assign word_done = take && (phase == 2'd2);

    // Staged word leaves when replaced, or at line end with eol
    assign push     = stg_vld && (word_done || line_end);
    assign push_eol = !word_done;

    assign empty = (wr_ptr == rd_ptr);
    assign full  = (wr_ptr[dprx_lnk_pkg::FIFO_AW] != rd_ptr[dprx_lnk_pkg::FIFO_AW])
                && (wr_ptr[dprx_lnk_pkg::FIFO_AW-1:0] == rd_ptr[dprx_lnk_pkg::FIFO_AW-1:0]);

    always_ff @(posedge lnk_clk)
    begin
        if (rst)
        begin
            phase    <= 2'd0;
            sof_pend <= 1'b0;
            stg_vld  <= 1'b0;
            ovf      <= 1'b0;
            wr_ptr   <= '0;
            rd_ptr   <= '0;
        end
        else
        begin
            if (line_end)
                phase <= 2'd0;                                  // Partial word discarded
            else if (take)
                phase <= word_done ? 2'd0 : phase + 2'd1;

            if (word_done)
                stg_vld <= 1'b1;
            else if (line_end)
                stg_vld <= 1'b0;

            // Armed by a vertical blanking line, used by the next word
            if (word_done)
                sof_pend <= 1'b0;
            else if (line_end && vblank)
                sof_pend <= 1'b1;

            if (push && full)
                ovf <= 1'b1;                                    // Word dropped
            else if (clr_ovf)
                ovf <= 1'b0;

            if (push && !full)
                wr_ptr <= wr_ptr + 1'b1;
            if (vid_vld && vid_rdy)
                rd_ptr <= rd_ptr + 1'b1;
        end
    end

    always_ff @(posedge lnk_clk)
    begin
        if (take && !phase[1])
            acc[phase[0]*dprx_lnk_pkg::PAIR_W +: dprx_lnk_pkg::PAIR_W] <= vid_bytes;
        if (word_done)
        begin
            stg_dat <= {vid_bytes, acc};                        // Last pair on top
            stg_sof <= sof_pend;
        end
        if (push && !full)
            mem[wr_ptr[dprx_lnk_pkg::FIFO_AW-1:0]] <= {stg_sof, push_eol, stg_dat};
    end

    // FIFO head drives the stream directly
    assign head    = mem[rd_ptr[dprx_lnk_pkg::FIFO_AW-1:0]];
    assign vid_vld = !empty;
    assign vid_dat = head[dprx_lnk_pkg::VID_W-1:0];
    assign vid_eol = vid_vld && head[dprx_lnk_pkg::VID_W];
    assign vid_sof = vid_vld && head[dprx_lnk_pkg::VID_W+1];

endmodule

//--- dprx_sdp_pack.sv
// Secondary data packer: pairs of lane byte pairs into 32 bit words with packet framing
`timescale 1ns/10ps

module dprx_sdp_pack
(
    input  logic                                lnk_clk,
    input  logic                                rst,
    input  logic                                sdp_en,
    input  logic                                sdp_byte_vld,
    input  logic [dprx_lnk_pkg::PAIR_W-1:0]     sdp_bytes,
    input  logic                                sdp_start,      // SS seen
    input  logic                                sdp_end,        // SE seen
    output logic                                sdp_sop,
    output logic                                sdp_eop,
    output logic [dprx_lnk_pkg::SDP_W-1:0]      sdp_dat,
    output logic                                sdp_vld
);

    logic                               phase;          // Second pair expected
    logic                               first;          // No word yet in this packet
    logic [dprx_lnk_pkg::PAIR_W-1:0]    lo;             // First pair of the word
    logic                               take;
    logic                               word_done;

    assign take      = sdp_en && sdp_byte_vld;
    assign word_done = take && phase;

    always_ff @(posedge lnk_clk)
    begin
        if (rst)
        begin
            phase   <= 1'b0;
            first   <= 1'b0;
            sdp_vld <= 1'b0;
            sdp_sop <= 1'b0;
        end
        else
        begin
            sdp_vld <= word_done;
            sdp_sop <= word_done && first;

            if (sdp_start)
                phase <= 1'b0;                  // Realign on every packet
            else if (take)
                phase <= !phase;

            if (sdp_start)
                first <= 1'b1;
            else if (word_done)
                first <= 1'b0;
        end
    end

    always_ff @(posedge lnk_clk)
    begin
        if (take && !phase)
            lo <= sdp_bytes;
        if (word_done)
            sdp_dat <= {sdp_bytes, lo};
    end

    // SE arrives one cycle after the last pair, together with the word
    assign sdp_eop = sdp_vld && sdp_end;

endmodule

//--- dprx_msg_ctl.sv
// Host message controller: four-phase req/ack responder, control register and status reply
`timescale 1ns/10ps

module dprx_msg_ctl
(
    input  logic                                lnk_clk,
    input  logic                                rst,
    input  logic                                host_req,
    input  dprx_msg_pkg::msg_word_t             host_wdat,      // Stable while req high
    input  logic                                lock,
    input  logic                                ovf,
    input  logic [7:0]                          lnk_vbid,
    output logic                                host_ack,       // Also the idle/ack state
    output dprx_msg_pkg::msg_word_t             host_rdat,      // Valid while ack high
    output logic                                vid_en,
    output logic                                sdp_en,
    output logic                                clr_ovf         // One cycle pulse
);

    logic                               req_new;        // Request seen while idle
    logic                               is_ctl;
    logic                               is_sta;
    dprx_msg_pkg::msg_sta_t             sta;

    assign req_new = host_req && !host_ack;
    assign is_ctl  = (host_wdat.ctl.id == dprx_msg_pkg::MSG_ID_CTL);
    assign is_sta  = (host_wdat.ctl.id == dprx_msg_pkg::MSG_ID_STA);

    // Status snapshot
    assign sta = '{id:   dprx_msg_pkg::MSG_ID_STA,
                   vbid: lnk_vbid,
                   ovf:  ovf,
                   lock: lock,
                   rsvd: 2'b00};

    always_ff @(posedge lnk_clk)
    begin
        if (rst)
        begin
            host_ack <= 1'b0;
            vid_en   <= 1'b0;
            sdp_en   <= 1'b0;
            clr_ovf  <= 1'b0;
        end
        else
        begin
            clr_ovf <= req_new && is_ctl && host_wdat.ctl.clr_ovf;

            if (req_new)
                host_ack <= 1'b1;
            else if (!host_req)
                host_ack <= 1'b0;                       // Host released req

            if (req_new && is_ctl)
            begin
                vid_en <= host_wdat.ctl.vid_en;
                sdp_en <= host_wdat.ctl.sdp_en;
            end
        end
    end

    // Reply captured with the request, held through the ack phase
    always_ff @(posedge lnk_clk)
    begin
        if (req_new)
        begin
            if (is_ctl)
                host_rdat <= host_wdat;                 // Echo
            else if (is_sta)
                host_rdat.sta <= sta;
            else
                host_rdat <= {dprx_msg_pkg::MSG_W{1'b0}};
        end
    end

endmodule

//--- dprx_top.sv
// Receive link top: symbol parser, video and secondary data packers, host message controller
`timescale 1ns/10ps

module dprx_top
(
    // Clock and reset
    input  logic                                lnk_clk,
    input  logic                                rst,

    // Link
    input  logic [dprx_lnk_pkg::LNK_W-1:0]      lnk_dat,        // Lane 0 in bits 8:0
    output logic                                lnk_sync,
    output logic [7:0]                          lnk_vbid,

    // Video stream
    input  logic                                vid_rdy,
    output logic                                vid_sof,
    output logic                                vid_eol,
    output logic [dprx_lnk_pkg::VID_W-1:0]      vid_dat,
    output logic                                vid_vld,

    // Secondary data stream
    output logic                                sdp_sop,
    output logic                                sdp_eop,
    output logic [dprx_lnk_pkg::SDP_W-1:0]      sdp_dat,
    output logic                                sdp_vld,

    // Host port, four-phase req/ack
    input  logic                                host_req,
    input  dprx_msg_pkg::msg_word_t             host_wdat,
    output logic                                host_ack,
    output dprx_msg_pkg::msg_word_t             host_rdat
);

    // Parser to packers
    logic                               lock;
    logic                               vblank;
    logic                               line_end;       // BS pulse
    logic                               vid_byte_vld;
    logic [dprx_lnk_pkg::PAIR_W-1:0]    vid_bytes;
    logic                               sdp_byte_vld;
    logic [dprx_lnk_pkg::PAIR_W-1:0]    sdp_bytes;
    logic                               sdp_start;
    logic                               sdp_end;

    // Controller to the rest
    logic                               vid_en;
    logic                               sdp_en;
    logic                               clr_ovf;
    logic                               ovf;            // Back from video packer

    // Port names match the wires above one to one
    dprx_lnk_parser parser_inst (.*);

    dprx_vid_pack vid_pack_inst (.*);

    dprx_sdp_pack sdp_pack_inst (.*);

    dprx_msg_ctl msg_ctl_inst (.*);

endmodule

//--- dprx_tb_checks.svh
// Typed compare tasks and failure reporting for the receive link testbench
`ifndef DPRX_TB_CHECKS_SVH
`define DPRX_TB_CHECKS_SVH

// Fail message and stop
task automatic end_in_failure();
    $display("TEST FAILED");
    $fatal(1, "simulation stopped at the first error");
endtask

// Wrong value seen on a DUT output
task automatic mismatch(input string what);
    $display("FAILED at %0d ns: %s", $time, what);
    end_in_failure();
endtask

// Protocol or run problem without a value
task automatic run_error(input string what);
    $display("%s", what);
    end_in_failure();
endtask

task automatic check_vid(input logic [dprx_lnk_pkg::VID_W-1:0] dat, input logic sof,
                         input logic eol, input logic [dprx_lnk_pkg::VID_W-1:0] exp_dat,
                         input logic exp_sof, input logic exp_eol);
    if (dat !== exp_dat || sof !== exp_sof || eol !== exp_eol)
        mismatch($sformatf("video word %h sof %b eol %b, expected %h sof %b eol %b",
                           dat, sof, eol, exp_dat, exp_sof, exp_eol));
endtask

task automatic check_sdp(input logic [dprx_lnk_pkg::SDP_W-1:0] dat, input logic sop,
                         input logic eop, input logic [dprx_lnk_pkg::SDP_W-1:0] exp_dat,
                         input logic exp_sop, input logic exp_eop);
    if (dat !== exp_dat || sop !== exp_sop || eop !== exp_eop)
        mismatch($sformatf("SDP word %h sop %b eop %b, expected %h sop %b eop %b",
                           dat, sop, eop, exp_dat, exp_sop, exp_eop));
endtask

task automatic check_msg(input dprx_msg_pkg::msg_word_t got, input dprx_msg_pkg::msg_word_t exp);
    if (got !== exp)
        mismatch($sformatf("host reply %h, expected %h", got, exp));
endtask

task automatic check_vbid(input logic [7:0] got, input logic [7:0] exp);
    if (got !== exp)
        mismatch($sformatf("lnk_vbid %h, expected %h", got, exp));
endtask

task automatic check_sync(input logic got, input logic exp);
    if (got !== exp)
        mismatch($sformatf("lnk_sync %b, expected %b", got, exp));
endtask

`endif

//--- dprx_tb.sv
// Receive link testbench that replays the trace into the DUT and checks streams, status and replies
`timescale 1ns/10ps

module dprx_tb;

    logic                               lnk_clk;
    logic                               rst;
    logic [dprx_lnk_pkg::LNK_W-1:0]     lnk_dat;
    logic                               lnk_sync;
    logic [7:0]                         lnk_vbid;
    logic                               vid_rdy;
    logic                               vid_sof;
    logic                               vid_eol;
    logic [dprx_lnk_pkg::VID_W-1:0]     vid_dat;
    logic                               vid_vld;
    logic                               sdp_sop;
    logic                               sdp_eop;
    logic [dprx_lnk_pkg::SDP_W-1:0]     sdp_dat;
    logic                               sdp_vld;
    logic                               host_req;
    dprx_msg_pkg::msg_word_t            host_wdat;
    logic                               host_ack;
    dprx_msg_pkg::msg_word_t            host_rdat;

    logic [dprx_lnk_pkg::VID_W+1:0]     vid_q[$];       // {sof, eol, dat}
    logic [dprx_lnk_pkg::SDP_W+1:0]     sdp_q[$];       // {sop, eop, dat}
    logic [dprx_lnk_pkg::VID_W+1:0]     vid_exp;
    logic [dprx_lnk_pkg::SDP_W+1:0]     sdp_exp;
    string                              trace[$];       // Whole trace with one entry per line
    int                                 rdy_mode;       // 0 low, 1 high, 2 random
    integer                             seed;
    integer                             rnd;
    longint                             watchdog_ns;    // Zero until the trace is loaded

    `include "dprx_tb_checks.svh"

    dprx_top DUT (.*);

    // 20 ns link clock
    initial
    begin
        lnk_clk = 1'b0;
        forever #10 lnk_clk = ~lnk_clk;
    end

    initial
    begin
        wait (watchdog_ns > 0);
        #(watchdog_ns);
        run_error("Watchdog expired, the trace did not finish in time");
    end

    // One symbol pair per falling edge with data bytes stepping on each repeat
    task automatic drive_pairs(input logic [8:0] s0, input logic [8:0] s1, input int count,
                               input logic [7:0] step);
        int i;
        for (i = 0; i < count; i++)
        begin
            @(negedge lnk_clk);
            check_sync(lnk_sync, lnk_dat[8:0] == {1'b1, dprx_lnk_pkg::K_BS});  // Held pair
            lnk_dat  = {s1, s0};
            s0[7:0] = s0[7:0] + step;
            s1[7:0] = s1[7:0] + step;
        end
    endtask

    // Four-phase request with ack edges one cycle after each req edge
    task automatic host_message(input dprx_msg_pkg::msg_word_t w,
                                input dprx_msg_pkg::msg_word_t exp);
        @(negedge lnk_clk);
        if (host_ack)
            run_error("host_ack still high before a new request");
        host_wdat = w;
        host_req  = 1'b1;
        @(negedge lnk_clk);
        if (!host_ack)
            run_error("host_ack did not rise one cycle after host_req");
        check_msg(host_rdat, exp);
        host_req = 1'b0;
        @(negedge lnk_clk);
        if (host_ack)
            run_error("host_ack did not fall one cycle after host_req dropped");
    endtask

    // Ready first and then compare what transfers at the next rising edge
    always @(negedge lnk_clk)
    begin
        rnd = $random(seed);
        case (rdy_mode)
            0:       vid_rdy = 1'b0;
            1:       vid_rdy = 1'b1;
            default: vid_rdy = rnd[0];
        endcase
        if (!rst && vid_vld && vid_rdy)
        begin
            if (vid_q.size() == 0)
                run_error("Video word arrived while none was expected");
            else
            begin
                vid_exp = vid_q.pop_front();
                check_vid(vid_dat, vid_sof, vid_eol, vid_exp[dprx_lnk_pkg::VID_W-1:0],
                          vid_exp[dprx_lnk_pkg::VID_W+1], vid_exp[dprx_lnk_pkg::VID_W]);
            end
        end
        if (!rst && sdp_vld)
        begin
            if (sdp_q.size() == 0)
                run_error("SDP word arrived while none was expected");
            else
            begin
                sdp_exp = sdp_q.pop_front();
                check_sdp(sdp_dat, sdp_sop, sdp_eop, sdp_exp[dprx_lnk_pkg::SDP_W-1:0],
                          sdp_exp[dprx_lnk_pkg::SDP_W+1], sdp_exp[dprx_lnk_pkg::SDP_W]);
            end
        end
    end

    initial
    begin : run_trace
        int                             fd;
        int                             n;
        int                             cnt;
        int                             f1;
        int                             f2;
        int                             drain;
        string                          line;
        byte                            kind;
        logic [8:0]                     s0;
        logic [8:0]                     s1;
        logic [7:0]                     step;
        logic [15:0]                    w16;
        logic [15:0]                    r16;
        logic [dprx_lnk_pkg::VID_W-1:0] vdat;
        logic [dprx_lnk_pkg::SDP_W-1:0] pdat;

        rst       = 1'b1;
        lnk_dat   = '0;
        vid_rdy   = 1'b0;
        host_req  = 1'b0;
        host_wdat = '0;
        rdy_mode  = 1;
        seed      = 30336;

        fd = $fopen("dprx_trace.txt", "r");
        if (fd == 0)
            run_error("Cannot open dprx_trace.txt");
        while (!$feof(fd))
        begin
            line = "";
            if ($fgets(line, fd) > 0)
                trace.push_back(line);
        end
        $fclose(fd);
        watchdog_ns = trace.size() * 10 * 20;       // 10 cycles of 20 ns per line

        repeat (3) @(posedge lnk_clk);
        @(negedge lnk_clk);
        rst = 1'b0;
        check_vbid(lnk_vbid, 8'h00);
        if (lnk_sync || vid_vld || vid_sof || vid_eol || sdp_vld || sdp_sop || sdp_eop
            || host_ack)
            run_error("Outputs not idle after reset");

        foreach (trace[i])
        begin
            line = trace[i];
            kind = line.getc(0);
            n    = 0;
            case (kind)
                "S":
                begin
                    n = $sscanf(line, "S %h %h %d %h", s0, s1, cnt, step);
                    drive_pairs(s0, s1, cnt, step);
                end
                "M":
                begin
                    n = 2 + $sscanf(line, "M %h %h", w16, r16);
                    host_message(w16, r16);
                end
                "V":
                begin
                    n = 1 + $sscanf(line, "V %h %d %d", vdat, f1, f2);
                    vid_q.push_back({f1[0], f2[0], vdat});
                end
                "P":
                begin
                    n = 1 + $sscanf(line, "P %h %d %d", pdat, f1, f2);
                    sdp_q.push_back({f1[0], f2[0], pdat});
                end
                "Y":
                begin
                    n = 3 + $sscanf(line, "Y %h", step);
                    check_vbid(lnk_vbid, step);
                end
                "R":
                begin
                    n = 3 + $sscanf(line, "R %d", cnt);
                    if (cnt == 0)
                        while (vid_q.size() != 0)
                            @(negedge lnk_clk);     // Drain before holding ready low
                    rdy_mode = cnt;
                end
                default:
                    n = 4;                          // Comment or blank line
            endcase
            if (n != 4)
                run_error($sformatf("Malformed trace line %0d: %s", i + 1, line));
        end

        // Let queued words come out
        drain = 0;
        while ((vid_q.size() != 0 || sdp_q.size() != 0) && drain < 25 * dprx_lnk_pkg::FIFO_DEPTH)
        begin
            @(negedge lnk_clk);
            drain++;
        end

        // Quiet tail so stray late words still reach the monitor
        repeat (2 * dprx_lnk_pkg::FIFO_DEPTH) @(posedge lnk_clk);

        if (vid_q.size() != 0 || sdp_q.size() != 0)
            run_error($sformatf("%0d video and %0d SDP words never arrived",
                                vid_q.size(), sdp_q.size()));
        else
        begin
            $display("TEST PASSED");
            $finish;
        end
    end

endmodule

//--- dprx_trace.txt
# S sym0 sym1 count step: lane symbols as {K, byte} hex, data bytes advance by step per repeat
# M wdat reply | V dat sof eol | P dat sop eop | Y vbid | R vid_rdy 0 low, 1 high, 2 random
R 1
M 2000 2000     # status after reset
M 1FF3 1FF3     # enables on, reserved bits echoed
M 7000 0000     # unknown id
S 1BC 1BC 1 0   # BS
S 001 001 2 0   # VB-ID 01, then idle
Y 01
M 2000 2014     # locked
S 1F7 1F7 1 0   # illegal K
M 2000 2010
R 2
V 151413121110 1 0
V 1B1A19181716 0 1
V 252423222120 0 1
S 1BC 1BC 1 0   # line end with vblank still set
S 000 000 2 0
S 1FB 1FB 1 0
S 010 011 6 2   # two words
S 1BC 1BC 1 0
S 000 000 2 0
S 1FB 1FB 1 0
S 020 021 3 2   # one word
S 1BC 1BC 1 0
S 000 000 2 0
M 1002 1002     # video off
S 1FB 1FB 1 0
S 0A0 0A1 6 2
S 1BC 1BC 1 0
S 000 000 2 0
R 0
M 1003 1003
V 353433323130 0 0
V 3B3A39383736 0 0
V 41403F3E3D3C 0 0
V 474645444342 0 0
S 1FB 1FB 1 0
S 030 031 18 2  # six words, last two dropped
S 1BC 1BC 1 0
S 000 000 2 0
M 2000 200C     # ovf and lock
M 1007 1007     # clear ovf
M 2000 2004
R 2
P 63626160 1 0
P 67666564 0 1
S 15C 15C 1 0   # SS in blanking
S 060 061 4 2
S 1FD 1FD 1 0
M 1001 1001     # SDP off
S 15C 15C 1 0
S 070 071 4 2
S 1FD 1FD 1 0

//--- vlog.f
+incdir+.
dprx_lnk_pkg.sv
dprx_msg_pkg.sv
dprx_lnk_parser.sv
dprx_vid_pack.sv
dprx_sdp_pack.sv
dprx_msg_ctl.sv
dprx_top.sv
dprx_tb.sv
